/* hdl/prehisle_io_config.svh */
// bus widths, control register count and 68000/z80 address map bounds
`ifndef PREHISLE_IO_CONFIG_SVH
`define PREHISLE_IO_CONFIG_SVH

// bus widths
`define M68K_AW         24
`define Z80_AW          16
`define DATA_W          16

// looped control registers
`define NUM_CTRL_REGS   7

// 68000 memory ranges
`define M68K_ROM_START      24'h000000
`define M68K_ROM_END        24'h03ffff
`define M68K_RAM_START      24'h070000
`define M68K_RAM_END        24'h073fff
`define M68K_TXT_RAM_START  24'h090000
`define M68K_TXT_RAM_END    24'h0907ff
`define M68K_SPR_START      24'h0a0000
`define M68K_SPR_END        24'h0a07ff
`define M68K_FG_RAM_START   24'h0b0000
`define M68K_FG_RAM_END     24'h0b3fff
`define M68K_PAL_START      24'h0d0000
`define M68K_PAL_END        24'h0d07ff

// 68000 input words
`define M68K_P2_ADDR        24'h0e0010
`define M68K_COIN_ADDR      24'h0e0020
`define M68K_P1_ADDR        24'h0e0040
`define M68K_DSW1_ADDR      24'h0e0042
`define M68K_DSW2_ADDR      24'h0e0044

// 68000 control register words
`define M68K_FG_SCROLL_Y    24'h0f0000
`define M68K_FG_SCROLL_X    24'h0f0010
`define M68K_BG_SCROLL_Y    24'h0f0020
`define M68K_BG_SCROLL_X    24'h0f0030
`define M68K_INVERT         24'h0f0046
`define M68K_FLIP           24'h0f0060
`define M68K_SOUND_CMD      24'h0f0070

// z80 memory map and io ports
`define Z80_RAM_START       16'hf000
`define Z80_RAM_END         16'hf7ff
`define Z80_LATCH_ADDR      16'hf800
`define Z80_IO_SOUND0       8'h00
`define Z80_IO_SOUND1       8'h20
`define Z80_IO_UPD          8'h40
`define Z80_IO_UPD_R        8'h80

`endif

/* hdl/prehisle_io_pkg.sv */
// control register index enum and select/input structs
`default_nettype none

package prehisle_io_pkg;

    // order matches the generate loop in the top level
    typedef enum logic [2:0] {
        FG_SCROLL_Y = 3'd0,
        FG_SCROLL_X = 3'd1,
        BG_SCROLL_Y = 3'd2,
        BG_SCROLL_X = 3'd3,
        INVERT      = 3'd4,
        FLIP        = 3'd5,
        SOUND_CMD   = 3'd6
    } ctrl_reg_e;

    // 68000 input port read selects
    typedef struct packed {
        logic p1;
        logic p2;
        logic coin;
        logic dsw1;
        logic dsw2;
    } m68k_in_sel_t;

    // z80 memory and io selects
    typedef struct packed {
        logic rom;
        logic ram;
        // sound command latch read
        logic latch;
        // ym3812 address / data
        logic sound0;
        logic sound1;
        // upd7759 write and reset
        logic upd;
        logic upd_r;
    } z80_sel_t;

    // 68000 memory selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic txt_ram;
        logic spr;
        logic pal;
        logic fg_ram;
    } m68k_mem_sel_t;

endpackage

`default_nettype wire

/* hdl/m68k_wr_if.sv */
// m68k_wr_if interface for the qualified 68000 register write bus
`default_nettype none
`include "prehisle_io_config.svh"

interface m68k_wr_if
(
    input logic clk
);

    // one write strobe per control register
    logic [`NUM_CTRL_REGS-1:0] wr_sel;
    // 68000 write data
    logic [`DATA_W-1:0]        wdata;
    // byte lane enables from uds_n / lds_n
    logic                      be_hi;
    logic                      be_lo;

    // address decoder side
    modport decoder
    (
        output wr_sel, wdata, be_hi, be_lo
    );

    // register bank side, sampled on clk
    modport reg_side
    (
        input clk, wr_sel, wdata, be_hi, be_lo
    );

endinterface

`default_nettype wire

/* hdl/chip_select.sv */
// chip_select module, combinational 68000 and z80 address decoder
`default_nettype none
`include "prehisle_io_config.svh"

module chip_select
    import prehisle_io_pkg::*;
(
    // 68000 bus
    input  logic [`M68K_AW-1:0] m68k_a,
    input  logic                m68k_as_n,
    input  logic                m68k_uds_n,
    input  logic                m68k_lds_n,
    input  logic                m68k_rw_n,
    input  logic [`DATA_W-1:0]  m68k_dout,

    // z80 bus
    input  logic [`Z80_AW-1:0]  z80_addr,
    input  logic                mreq_n,
    input  logic                iorq_n,
    input  logic                rfsh_n,

    output m68k_mem_sel_t       mem_sel,
    output m68k_in_sel_t        in_sel,
    output z80_sel_t            z80_sel,
    m68k_wr_if.decoder          wr
);

    // address strobe plus at least one data strobe
    logic m68k_cycle;
    // z80 memory cycle outside refresh
    logic z80_mem_cycle;

    // inclusive range match
    function automatic logic m68k_range
    (
        input logic [`M68K_AW-1:0] addr,
        input logic [`M68K_AW-1:0] lo,
        input logic [`M68K_AW-1:0] hi
    );
        return (addr >= lo) && (addr <= hi);
    endfunction

    // word match, a0 ignored
    function automatic logic m68k_word
    (
        input logic [`M68K_AW-1:0] addr,
        input logic [`M68K_AW-1:0] base
    );
        return addr[`M68K_AW-1:1] == base[`M68K_AW-1:1];
    endfunction

    assign m68k_cycle    = !m68k_as_n && !(m68k_uds_n && m68k_lds_n);
    assign z80_mem_cycle = !mreq_n && rfsh_n;

    // memory ranges
    always_comb
    begin
        mem_sel.rom     = m68k_cycle && m68k_range(m68k_a, `M68K_ROM_START, `M68K_ROM_END);
        mem_sel.ram     = m68k_cycle && m68k_range(m68k_a, `M68K_RAM_START, `M68K_RAM_END);
        mem_sel.txt_ram = m68k_cycle &&
                          m68k_range(m68k_a, `M68K_TXT_RAM_START, `M68K_TXT_RAM_END);
        mem_sel.spr     = m68k_cycle && m68k_range(m68k_a, `M68K_SPR_START, `M68K_SPR_END);
        mem_sel.pal     = m68k_cycle && m68k_range(m68k_a, `M68K_PAL_START, `M68K_PAL_END);
        mem_sel.fg_ram  = m68k_cycle &&
                          m68k_range(m68k_a, `M68K_FG_RAM_START, `M68K_FG_RAM_END);
    end

    // input port words, any direction
    always_comb
    begin
        in_sel.p2   = m68k_cycle && m68k_word(m68k_a, `M68K_P2_ADDR);
        in_sel.coin = m68k_cycle && m68k_word(m68k_a, `M68K_COIN_ADDR);
        // p1 sits in the low byte
        in_sel.p1   = m68k_cycle && m68k_word(m68k_a, `M68K_P1_ADDR);
        in_sel.dsw1 = m68k_cycle && m68k_word(m68k_a, `M68K_DSW1_ADDR);
        in_sel.dsw2 = m68k_cycle && m68k_word(m68k_a, `M68K_DSW2_ADDR);
    end

    // control register writes need rw_n low
    always_comb
    begin
        wr.wr_sel = '0;
        if (m68k_cycle && !m68k_rw_n)
        begin
            wr.wr_sel[FG_SCROLL_Y] = m68k_word(m68k_a, `M68K_FG_SCROLL_Y);
            wr.wr_sel[FG_SCROLL_X] = m68k_word(m68k_a, `M68K_FG_SCROLL_X);
            wr.wr_sel[BG_SCROLL_Y] = m68k_word(m68k_a, `M68K_BG_SCROLL_Y);
            wr.wr_sel[BG_SCROLL_X] = m68k_word(m68k_a, `M68K_BG_SCROLL_X);
            wr.wr_sel[INVERT]      = m68k_word(m68k_a, `M68K_INVERT);
            wr.wr_sel[FLIP]        = m68k_word(m68k_a, `M68K_FLIP);
            wr.wr_sel[SOUND_CMD]   = m68k_word(m68k_a, `M68K_SOUND_CMD);
        end
    end

    // data and lane enables pass straight to the register bank
    assign wr.wdata = m68k_dout;
    assign wr.be_hi = !m68k_uds_n;
    assign wr.be_lo = !m68k_lds_n;

    // z80 memory and io space
    always_comb
    begin
        // rom fills everything below ram
        z80_sel.rom    = z80_mem_cycle && (z80_addr < `Z80_RAM_START);
        z80_sel.ram    = z80_mem_cycle && (z80_addr >= `Z80_RAM_START) &&
                         (z80_addr <= `Z80_RAM_END);
        z80_sel.latch  = z80_mem_cycle && (z80_addr == `Z80_LATCH_ADDR);
        // io decode only looks at the low address byte
        z80_sel.sound0 = !iorq_n && (z80_addr[7:0] == `Z80_IO_SOUND0);
        z80_sel.sound1 = !iorq_n && (z80_addr[7:0] == `Z80_IO_SOUND1);
        z80_sel.upd    = !iorq_n && (z80_addr[7:0] == `Z80_IO_UPD);
        z80_sel.upd_r  = !iorq_n && (z80_addr[7:0] == `Z80_IO_UPD_R);
    end

endmodule

`default_nettype wire

/* hdl/ctrl_reg.sv */
// ctrl_reg module, byte-lane writable control register
`default_nettype none
`include "prehisle_io_config.svh"

module ctrl_reg
(
    input  logic               clk,
    input  logic               rst_n,
    // this register's wr_sel bit
    input  logic               sel,
    m68k_wr_if.reg_side        wr,
    output logic [`DATA_W-1:0] q
);

    localparam int BYTE_W = `DATA_W / 2;

    // upper and lower byte lanes load on their own enables
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            q <= '0;
        end
        else
        begin
            // uds_n lane
            if (sel && wr.be_hi)
            begin
                q[`DATA_W-1:BYTE_W] <= wr.wdata[`DATA_W-1:BYTE_W];
            end
            // lds_n lane
            if (sel && wr.be_lo)
            begin
                q[BYTE_W-1:0] <= wr.wdata[BYTE_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/io_read_mux.sv */
// io_read_mux module, 68000 and z80 read data with player 1 inversion
`default_nettype none
`include "prehisle_io_config.svh"

module io_read_mux
    import prehisle_io_pkg::*;
(
    input  m68k_in_sel_t       in_sel,
    input  logic               z80_latch_sel,

    // board inputs
    input  logic [7:0]         input_p1,
    input  logic [`DATA_W-1:0] input_p2,
    input  logic [`DATA_W-1:0] input_coin,
    input  logic [`DATA_W-1:0] input_dsw1,
    input  logic [`DATA_W-1:0] input_dsw2,

    // register values
    input  logic [`DATA_W-1:0] invert_val,
    input  logic [`DATA_W-1:0] sound_cmd_val,

    output logic [`DATA_W-1:0] m68k_din,
    output logic [7:0]         z80_din
);

    // any non-zero invert write flips all p1 bits
    logic [7:0] p1_mask;

    assign p1_mask = (invert_val != '0) ? 8'hff : 8'h00;

    // 68000 read data
    always_comb
    begin
        if (in_sel.p1)
        begin
            // upper byte floats high
            m68k_din = {8'hff, input_p1 ^ p1_mask};
        end
        else if (in_sel.p2)
        begin
            m68k_din = input_p2;
        end
        else if (in_sel.coin)
        begin
            m68k_din = input_coin;
        end
        else if (in_sel.dsw1)
        begin
            m68k_din = input_dsw1;
        end
        else if (in_sel.dsw2)
        begin
            m68k_din = input_dsw2;
        end
        else
        begin
            // unmapped reads return all ones
            m68k_din = '1;
        end
    end

    // z80 sees only the low byte of the sound command
    assign z80_din = z80_latch_sel ? sound_cmd_val[7:0] : 8'hff;

endmodule

`default_nettype wire

/* hdl/prehisle_io.sv */
// prehisle_io top level, decoder, control register bank and read mux
`default_nettype none
`include "prehisle_io_config.svh"

module prehisle_io
    import prehisle_io_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // 68000 bus
    input  logic [`M68K_AW-1:0] m68k_a,
    input  logic                m68k_as_n,
    input  logic                m68k_uds_n,
    input  logic                m68k_lds_n,
    input  logic                m68k_rw_n,
    input  logic [`DATA_W-1:0]  m68k_dout,
    output logic [`DATA_W-1:0]  m68k_din,

    // z80 bus
    input  logic [`Z80_AW-1:0]  z80_addr,
    input  logic                mreq_n,
    input  logic                iorq_n,
    input  logic                rfsh_n,
    output logic [7:0]          z80_din,

    // player, coin and dip inputs
    input  logic [7:0]          input_p1,
    input  logic [`DATA_W-1:0]  input_p2,
    input  logic [`DATA_W-1:0]  input_coin,
    input  logic [`DATA_W-1:0]  input_dsw1,
    input  logic [`DATA_W-1:0]  input_dsw2,

    // 68000 memory selects
    output logic                m68k_rom_cs,
    output logic                m68k_ram_cs,
    output logic                m68k_txt_ram_cs,
    output logic                m68k_spr_cs,
    output logic                m68k_pal_cs,
    output logic                m68k_fg_ram_cs,

    // z80 selects
    output logic                z80_rom_cs,
    output logic                z80_ram_cs,
    output logic                z80_sound0_cs,
    output logic                z80_sound1_cs,
    output logic                z80_upd_cs,
    output logic                z80_upd_r_cs,

    // register outputs to video and sound
    output logic [`DATA_W-1:0]  fg_scroll_x,
    output logic [`DATA_W-1:0]  fg_scroll_y,
    output logic [`DATA_W-1:0]  bg_scroll_x,
    output logic [`DATA_W-1:0]  bg_scroll_y,
    output logic                flip_screen,
    output logic [7:0]          sound_latch
);

    m68k_mem_sel_t      mem_sel;
    m68k_in_sel_t       in_sel;
    z80_sel_t           z80_sel;
    // register bank, indexed by ctrl_reg_e
    logic [`DATA_W-1:0] ctrl_q [`NUM_CTRL_REGS];

    m68k_wr_if wr_bus (.clk(clk));

    chip_select i_chip_select
    (
        .m68k_a     (m68k_a),
        .m68k_as_n  (m68k_as_n),
        .m68k_uds_n (m68k_uds_n),
        .m68k_lds_n (m68k_lds_n),
        .m68k_rw_n  (m68k_rw_n),
        .m68k_dout  (m68k_dout),
        .z80_addr   (z80_addr),
        .mreq_n     (mreq_n),
        .iorq_n     (iorq_n),
        .rfsh_n     (rfsh_n),
        .mem_sel    (mem_sel),
        .in_sel     (in_sel),
        .z80_sel    (z80_sel),
        .wr         (wr_bus.decoder)
    );

    // one register per wr_sel bit
    for (genvar i = 0; i < `NUM_CTRL_REGS; i++)
    begin : g_ctrl
        ctrl_reg i_ctrl_reg
        (
            .clk   (clk),
            .rst_n (rst_n),
            .sel   (wr_bus.wr_sel[i]),
            .wr    (wr_bus.reg_side),
            .q     (ctrl_q[i])
        );
    end

    io_read_mux i_io_read_mux
    (
        .in_sel        (in_sel),
        .z80_latch_sel (z80_sel.latch),
        .input_p1      (input_p1),
        .input_p2      (input_p2),
        .input_coin    (input_coin),
        .input_dsw1    (input_dsw1),
        .input_dsw2    (input_dsw2),
        .invert_val    (ctrl_q[INVERT]),
        .sound_cmd_val (ctrl_q[SOUND_CMD]),
        .m68k_din      (m68k_din),
        .z80_din       (z80_din)
    );

    // select structs out to plain ports
    assign m68k_rom_cs     = mem_sel.rom;
    assign m68k_ram_cs     = mem_sel.ram;
    assign m68k_txt_ram_cs = mem_sel.txt_ram;
    assign m68k_spr_cs     = mem_sel.spr;
    assign m68k_pal_cs     = mem_sel.pal;
    assign m68k_fg_ram_cs  = mem_sel.fg_ram;

    assign z80_rom_cs      = z80_sel.rom;
    assign z80_ram_cs      = z80_sel.ram;
    assign z80_sound0_cs   = z80_sel.sound0;
    assign z80_sound1_cs   = z80_sel.sound1;
    assign z80_upd_cs      = z80_sel.upd;
    assign z80_upd_r_cs    = z80_sel.upd_r;

    // register bank out
    assign fg_scroll_y     = ctrl_q[FG_SCROLL_Y];
    assign fg_scroll_x     = ctrl_q[FG_SCROLL_X];
    assign bg_scroll_y     = ctrl_q[BG_SCROLL_Y];
    assign bg_scroll_x     = ctrl_q[BG_SCROLL_X];
    // only bit 0 of flip matters
    assign flip_screen     = ctrl_q[FLIP][0];
    assign sound_latch     = ctrl_q[SOUND_CMD][7:0];

endmodule

`default_nettype wire

/* verification/prehisle_io_tb.sv */
// prehisle_io_tb testbench, stimulus table, reference register model, compare tasks, watchdog
`default_nettype none
`include "prehisle_io_config.svh"

module prehisle_io_tb
    import prehisle_io_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    // cycle kinds, idle means as_n high on the 68000 and refresh on the z80
    localparam int KIND_READ  = 0;
    localparam int KIND_WRITE = 1;
    localparam int KIND_IO    = 2;
    localparam int KIND_IDLE  = 3;

    localparam m68k_mem_sel_t MEM_NONE = 6'b000000;
    localparam m68k_mem_sel_t MEM_ROM  = 6'b100000;
    localparam m68k_mem_sel_t MEM_RAM  = 6'b010000;
    localparam m68k_mem_sel_t MEM_TXT  = 6'b001000;
    localparam m68k_mem_sel_t MEM_SPR  = 6'b000100;
    localparam m68k_mem_sel_t MEM_PAL  = 6'b000010;
    localparam m68k_mem_sel_t MEM_FG   = 6'b000001;
    localparam z80_sel_t      Z_NONE   = 7'b0000000;
    localparam z80_sel_t      Z_ROM    = 7'b1000000;
    localparam z80_sel_t      Z_RAM    = 7'b0100000;
    localparam z80_sel_t      Z_LATCH  = 7'b0010000;
    localparam z80_sel_t      Z_S0     = 7'b0001000;
    localparam z80_sel_t      Z_S1     = 7'b0000100;
    localparam z80_sel_t      Z_UPD    = 7'b0000010;
    localparam z80_sel_t      Z_UPD_R  = 7'b0000001;

    typedef struct {
        bit                   z80;
        int                   kind;
        logic [`M68K_AW-1:0]  addr;
        // {uds, lds} as active-high enables
        logic [1:0]           be;
        logic [`DATA_W-1:0]   wdata;
        m68k_mem_sel_t        exp_mem;
        z80_sel_t             exp_z80;
    } entry_t;

    logic clk;
    logic rst_n;
    logic [`M68K_AW-1:0] m68k_a;
    logic m68k_as_n, m68k_uds_n, m68k_lds_n, m68k_rw_n;
    logic [`DATA_W-1:0] m68k_dout, m68k_din;
    logic [`Z80_AW-1:0] z80_addr;
    logic mreq_n, iorq_n, rfsh_n;
    logic [7:0] z80_din, input_p1, sound_latch;
    logic [`DATA_W-1:0] input_p2, input_coin, input_dsw1, input_dsw2;
    logic m68k_rom_cs, m68k_ram_cs, m68k_txt_ram_cs, m68k_spr_cs, m68k_pal_cs, m68k_fg_ram_cs;
    logic z80_rom_cs, z80_ram_cs, z80_sound0_cs, z80_sound1_cs, z80_upd_cs, z80_upd_r_cs;
    logic [`DATA_W-1:0] fg_scroll_x, fg_scroll_y, bg_scroll_x, bg_scroll_y;
    logic flip_screen;

    entry_t stim_table[$];
    bit table_ready;
    int errors;
    int checks;
    integer seed;
    // reference copy of the register bank, indexed by ctrl_reg_e
    logic [`DATA_W-1:0] model_q [`NUM_CTRL_REGS];
    logic [`M68K_AW-1:0] reg_addr [`NUM_CTRL_REGS];

    prehisle_io i_prehisle_io (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_m68k_mem_sel(string name, m68k_mem_sel_t exp, m68k_mem_sel_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_z80_sel(string name, z80_sel_t exp, z80_sel_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(string name, logic [`DATA_W-1:0] exp, logic [`DATA_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic add_entry(bit z80, int kind, logic [`M68K_AW-1:0] addr, logic [1:0] be,
                             logic [`DATA_W-1:0] wdata, m68k_mem_sel_t em, z80_sel_t ez);
        entry_t e;
        e = '{z80, kind, addr, be, wdata, em, ez};
        stim_table.push_back(e);
    endtask

    // first, last and one past the end of a 68000 range
    task automatic add_range(logic [`M68K_AW-1:0] lo, logic [`M68K_AW-1:0] hi, m68k_mem_sel_t sel);
        add_entry(0, KIND_READ, lo, 2'b11, '0, sel, Z_NONE);
        add_entry(0, KIND_READ, hi, 2'b11, '0, sel, Z_NONE);
        add_entry(0, KIND_READ, hi + 1, 2'b11, '0, MEM_NONE, Z_NONE);
    endtask

    function automatic bit same_word(logic [`M68K_AW-1:0] a, logic [`M68K_AW-1:0] b);
        return a[`M68K_AW-1:1] == b[`M68K_AW-1:1];
    endfunction

    function automatic int reg_of(logic [`M68K_AW-1:0] addr);
        for (int i = 0; i < `NUM_CTRL_REGS; i++)
        begin
            if (same_word(addr, reg_addr[i]))
                return i;
        end
        return -1;
    endfunction

    // 68000 read data from the input map
    function automatic logic [`DATA_W-1:0] exp_m68k_din(entry_t e);
        if (e.z80 || e.kind == KIND_IDLE || e.be == 2'b00)
            return 16'hffff;
        if (same_word(e.addr, `M68K_P1_ADDR))
        begin
            // player 1 reads back inverted while invert holds any non-zero value
            if (model_q[INVERT] != 0)
                return {8'hff, ~input_p1};
            return {8'hff, input_p1};
        end
        if (same_word(e.addr, `M68K_P2_ADDR))
            return input_p2;
        if (same_word(e.addr, `M68K_COIN_ADDR))
            return input_coin;
        if (same_word(e.addr, `M68K_DSW1_ADDR))
            return input_dsw1;
        if (same_word(e.addr, `M68K_DSW2_ADDR))
            return input_dsw2;
        return 16'hffff;
    endfunction

    // expected latch select picks the sound command byte
    function automatic logic [7:0] exp_z80_din(entry_t e);
        if (e.exp_z80.latch)
            return model_q[SOUND_CMD][7:0];
        return 8'hff;
    endfunction

    // byte lanes of the written register
    task automatic update_model(entry_t e);
        int idx;
        idx = reg_of(e.addr);
        if (!e.z80 && e.kind == KIND_WRITE && idx >= 0)
        begin
            if (e.be[1])
                model_q[idx][15:8] = e.wdata[15:8];
            if (e.be[0])
                model_q[idx][7:0] = e.wdata[7:0];
        end
    endtask

    task automatic check_regs();
        check_word("fg_scroll_y", model_q[FG_SCROLL_Y], fg_scroll_y);
        check_word("fg_scroll_x", model_q[FG_SCROLL_X], fg_scroll_x);
        check_word("bg_scroll_y", model_q[BG_SCROLL_Y], bg_scroll_y);
        check_word("bg_scroll_x", model_q[BG_SCROLL_X], bg_scroll_x);
        check_word("flip_screen", {15'b0, model_q[FLIP][0]}, {15'b0, flip_screen});
        check_byte("sound_latch", model_q[SOUND_CMD][7:0], sound_latch);
    endtask

    task automatic idle_bus();
        m68k_as_n  <= 1'b1;
        m68k_uds_n <= 1'b1;
        m68k_lds_n <= 1'b1;
        m68k_rw_n  <= 1'b1;
        mreq_n     <= 1'b1;
        iorq_n     <= 1'b1;
        rfsh_n     <= 1'b1;
    endtask

    task automatic apply_entry(entry_t e);
        z80_sel_t act_z80;
        z80_sel_t exp_z80;
        @(posedge clk);
        idle_bus();
        if (!e.z80)
        begin
            m68k_a     <= e.addr;
            m68k_as_n  <= (e.kind == KIND_IDLE);
            m68k_uds_n <= !e.be[1];
            m68k_lds_n <= !e.be[0];
            m68k_rw_n  <= (e.kind != KIND_WRITE);
            m68k_dout  <= e.wdata;
        end
        else
        begin
            z80_addr <= e.addr[`Z80_AW-1:0];
            mreq_n   <= !(e.kind == KIND_READ || e.kind == KIND_IDLE);
            iorq_n   <= (e.kind != KIND_IO);
            rfsh_n   <= (e.kind != KIND_IDLE);
        end
        // selects and read data settle well before the falling edge
        @(negedge clk);
        // latch select has no top port, seen through z80_din
        exp_z80 = e.exp_z80;
        exp_z80.latch = 1'b0;
        act_z80 = {z80_rom_cs, z80_ram_cs, 1'b0, z80_sound0_cs, z80_sound1_cs,
                   z80_upd_cs, z80_upd_r_cs};
        check_m68k_mem_sel("m68k_mem_sel", e.exp_mem, {m68k_rom_cs, m68k_ram_cs,
                           m68k_txt_ram_cs, m68k_spr_cs, m68k_pal_cs, m68k_fg_ram_cs});
        check_z80_sel("z80_sel", exp_z80, act_z80);
        check_word("m68k_din", exp_m68k_din(e), m68k_din);
        check_byte("z80_din", exp_z80_din(e), z80_din);
        // registers still hold the old value before the edge
        check_regs();
        // register loads on this edge
        @(posedge clk);
        idle_bus();
        update_model(e);
        @(negedge clk);
        check_regs();
    endtask

    task automatic build_table();
        add_range(`M68K_ROM_START, `M68K_ROM_END, MEM_ROM);
        add_range(`M68K_RAM_START, `M68K_RAM_END, MEM_RAM);
        add_range(`M68K_TXT_RAM_START, `M68K_TXT_RAM_END, MEM_TXT);
        add_range(`M68K_SPR_START, `M68K_SPR_END, MEM_SPR);
        add_range(`M68K_FG_RAM_START, `M68K_FG_RAM_END, MEM_FG);
        add_range(`M68K_PAL_START, `M68K_PAL_END, MEM_PAL);
        add_entry(0, KIND_IDLE, 24'h000100, 2'b11, '0, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, 24'h070010, 2'b00, '0, MEM_NONE, Z_NONE);
        // full-word writes to every control register
        add_entry(0, KIND_WRITE, `M68K_FG_SCROLL_Y, 2'b11, 16'h1234, MEM_NONE, Z_NONE);
        add_entry(0, KIND_WRITE, `M68K_FG_SCROLL_X, 2'b11, 16'h2345, MEM_NONE, Z_NONE);
        add_entry(0, KIND_WRITE, `M68K_BG_SCROLL_Y, 2'b11, 16'h3456, MEM_NONE, Z_NONE);
        add_entry(0, KIND_WRITE, `M68K_BG_SCROLL_X, 2'b11, 16'h4567, MEM_NONE, Z_NONE);
        add_entry(0, KIND_WRITE, `M68K_INVERT, 2'b11, 16'h0000, MEM_NONE, Z_NONE);
        add_entry(0, KIND_WRITE, `M68K_FLIP, 2'b11, 16'h0001, MEM_NONE, Z_NONE);
        add_entry(0, KIND_WRITE, `M68K_SOUND_CMD, 2'b11, 16'h00a5, MEM_NONE, Z_NONE);
        // single lanes, then a read that must not write
        add_entry(0, KIND_WRITE, `M68K_FG_SCROLL_Y, 2'b10, 16'habcd, MEM_NONE, Z_NONE);
        add_entry(0, KIND_WRITE, `M68K_FG_SCROLL_X, 2'b01, 16'habcd, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, `M68K_BG_SCROLL_Y, 2'b11, 16'hffff, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, `M68K_P1_ADDR, 2'b11, '0, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, `M68K_P2_ADDR, 2'b11, '0, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, `M68K_COIN_ADDR, 2'b11, '0, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, `M68K_DSW1_ADDR, 2'b11, '0, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, `M68K_DSW2_ADDR, 2'b11, '0, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, 24'h0e0050, 2'b11, '0, MEM_NONE, Z_NONE);
        // invert non-zero through the upper byte only
        add_entry(0, KIND_WRITE, `M68K_INVERT, 2'b10, 16'h0100, MEM_NONE, Z_NONE);
        add_entry(0, KIND_READ, `M68K_P1_ADDR, 2'b01, '0, MEM_NONE, Z_NONE);
        // z80 memory, refresh and io
        add_entry(1, KIND_READ, 24'h0000, 2'b00, '0, MEM_NONE, Z_ROM);
        add_entry(1, KIND_READ, 24'hefff, 2'b00, '0, MEM_NONE, Z_ROM);
        add_entry(1, KIND_READ, 24'hf000, 2'b00, '0, MEM_NONE, Z_RAM);
        add_entry(1, KIND_READ, 24'hf7ff, 2'b00, '0, MEM_NONE, Z_RAM);
        add_entry(1, KIND_READ, 24'hf800, 2'b00, '0, MEM_NONE, Z_LATCH);
        add_entry(1, KIND_READ, 24'hf801, 2'b00, '0, MEM_NONE, Z_NONE);
        add_entry(1, KIND_IDLE, 24'h0000, 2'b00, '0, MEM_NONE, Z_NONE);
        add_entry(1, KIND_IDLE, 24'hf800, 2'b00, '0, MEM_NONE, Z_NONE);
        add_entry(1, KIND_IO, 24'h0000, 2'b00, '0, MEM_NONE, Z_S0);
        add_entry(1, KIND_IO, 24'h0020, 2'b00, '0, MEM_NONE, Z_S1);
        add_entry(1, KIND_IO, 24'h1240, 2'b00, '0, MEM_NONE, Z_UPD);
        add_entry(1, KIND_IO, 24'h0080, 2'b00, '0, MEM_NONE, Z_UPD_R);
        add_entry(1, KIND_IO, 24'h0010, 2'b00, '0, MEM_NONE, Z_NONE);
        // new sound command from the 68000 seen by the z80
        add_entry(0, KIND_WRITE, `M68K_SOUND_CMD, 2'b01, 16'h335a, MEM_NONE, Z_NONE);
        add_entry(1, KIND_READ, 24'hf800, 2'b00, '0, MEM_NONE, Z_LATCH);
    endtask

    initial
    begin
        seed = 89;
        reg_addr = '{`M68K_FG_SCROLL_Y, `M68K_FG_SCROLL_X, `M68K_BG_SCROLL_Y,
                     `M68K_BG_SCROLL_X, `M68K_INVERT, `M68K_FLIP, `M68K_SOUND_CMD};
        for (int i = 0; i < `NUM_CTRL_REGS; i++)
            model_q[i] = '0;
        rst_n      = 1'b0;
        m68k_a     = '0;
        m68k_dout  = '0;
        z80_addr   = '0;
        m68k_as_n  = 1'b1;
        m68k_uds_n = 1'b1;
        m68k_lds_n = 1'b1;
        m68k_rw_n  = 1'b1;
        mreq_n     = 1'b1;
        iorq_n     = 1'b1;
        rfsh_n     = 1'b1;
        input_p1   = 8'($random(seed));
        input_p2   = 16'($random(seed));
        input_coin = 16'($random(seed));
        input_dsw1 = 16'($random(seed));
        input_dsw2 = 16'($random(seed));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // registers cleared by reset
        @(negedge clk);
        check_regs();
        foreach (stim_table[i])
            apply_entry(stim_table[i]);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // two cycles per entry, doubled for margin
    initial
    begin
        wait (table_ready);
        #((RESET_CYCLES + stim_table.size() * 4) * CLK_PERIOD);
        $display("watchdog expired before the stimulus table finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* prehisle_io.f */
+incdir+hdl
hdl/prehisle_io_pkg.sv
hdl/m68k_wr_if.sv
hdl/chip_select.sv
hdl/ctrl_reg.sv
hdl/io_read_mux.sv
hdl/prehisle_io.sv
verification/prehisle_io_tb.sv
